//--- hw/cpuConfig.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and register file widths
`define DATA_BITS 32
`define REG_NO_BITS 4
`define IMM_BITS 16

// Reset program counter
`define START_PC 32'h100

// Memory depths as log2 of the word count
`define IMEM_WORD_BITS 10
`define DMEM_WORD_BITS 10

// Memory-mapped outputs live at and above IO_BASE
`define IO_BASE 32'hFFFFF000
`define ADDR_HEX 32'hFFFFF000
`define ADDR_LEDR 32'hFFFFF020

// Output device sizes
`define LEDR_BITS 10
`define HEX_DIGITS 6
`define HEX_RESET 24'hFEDEAD

`endif

//--- hw/cpuPkg.sv
`include "cpuConfig.svh"

package cpuPkg;

  typedef logic [`DATA_BITS-1:0] word_t;
  typedef logic [`REG_NO_BITS-1:0] regNo_t;
  typedef logic [`IMM_BITS-1:0] imm_t;

  // Primary opcode, instruction bits 31:26
  typedef enum logic [5:0] {
    ALUR = 6'b000000,
    BEQ  = 6'b001000,
    BLT  = 6'b001001,
    BLE  = 6'b001010,
    BNE  = 6'b001011,
    JAL  = 6'b001100,
    LW   = 6'b010010,
    SW   = 6'b011010,
    ADDI = 6'b100000,
    ANDI = 6'b100100,
    ORI  = 6'b100101,
    XORI = 6'b100110
  } op1_e;

  // Secondary opcode for ALUR, instruction bits 25:18
  typedef enum logic [7:0] {
    EQ   = 8'b00001000,
    LT   = 8'b00001001,
    LE   = 8'b00001010,
    NE   = 8'b00001011,
    ADD  = 8'b00100000,
    AND  = 8'b00100100,
    OR   = 8'b00100101,
    XOR  = 8'b00100110,
    SUB  = 8'b00101000,
    NAND = 8'b00101100,
    NOR  = 8'b00101101,
    NXOR = 8'b00101110,
    RSHF = 8'b00110000,
    LSHF = 8'b00110001
  } op2_e;

  typedef struct packed {
    word_t inst;
    word_t pcPlus4;
  } feLatch_t;

  typedef struct packed {
    op1_e   op1;
    op2_e   op2;
    word_t  imm;
    word_t  rsVal;
    word_t  rtVal;
    word_t  pcPlus4;
    regNo_t writeNo;
    logic   isBranch;
    logic   isJump;
    logic   readMem;
    logic   writeMem;
    logic   writeReg;
  } idLatch_t;

  typedef struct packed {
    word_t  result;
    word_t  storeData;
    regNo_t writeNo;
    logic   readMem;
    logic   writeMem;
    logic   writeReg;
  } exLatch_t;

  typedef struct packed {
    logic   en;
    regNo_t no;
    word_t  value;
  } regWrite_t;

  typedef struct packed {
    word_t addr;
    word_t wrData;
    logic  write;
  } ioReq_t;

endpackage

//--- hw/fetchStage.sv
`timescale 1ns/100ps
`include "cpuConfig.svh"

module fetchStage import cpuPkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  logic     redirect,
  input  word_t    redirectPc,
  input  logic     loadEn,
  input  word_t    loadAddr,
  input  word_t    loadData,
  output feLatch_t feOut
);

  localparam int imemWords = 1 << `IMEM_WORD_BITS;

  word_t pc;
  word_t pcPlus4;
  word_t fetched;
  word_t imem [imemWords];

  // Program load port, used while the core sits in reset
  always_ff @(posedge clk) begin
    if (loadEn) begin
      imem[loadAddr[`IMEM_WORD_BITS+1:2]] <= loadData;
    end
  end

  assign fetched = imem[pc[`IMEM_WORD_BITS+1:2]];
  assign pcPlus4 = pc + 4;

  // Redirect wins over stall and flushes the fetch latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= `START_PC;
      feOut <= '0;
    end else if (redirect) begin
      pc <= redirectPc;
      feOut <= '0;
    end else if (!stall) begin
      pc <= pcPlus4;
      feOut <= '{inst: fetched, pcPlus4: pcPlus4};
    end
  end

endmodule

//--- hw/decodeStage.sv
`timescale 1ns/100ps
`include "cpuConfig.svh"

module decodeStage import cpuPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  feLatch_t  feIn,
  input  logic      redirect,
  input  word_t     exFwd,
  input  word_t     memFwd,
  input  regNo_t    exWriteNo,
  input  logic      exWriteEn,
  input  regWrite_t wbIn,
  output logic      stall,
  output idLatch_t  idOut
);

  localparam int numRegs = 1 << `REG_NO_BITS;

  word_t    regs [numRegs];
  op1_e     op1;
  imm_t     immRaw;
  regNo_t   rd;
  regNo_t   rs;
  regNo_t   rt;
  word_t    rsFile;
  word_t    rtFile;
  logic     readsRt;
  logic     rsExDep;
  logic     rtExDep;
  logic     rsMemDep;
  logic     rtMemDep;
  idLatch_t idNext;

  // Instruction fields
  assign op1    = op1_e'(feIn.inst[31:26]);
  assign immRaw = feIn.inst[23:8];
  assign rd     = feIn.inst[11:8];
  assign rs     = feIn.inst[7:4];
  assign rt     = feIn.inst[3:0];

  // Register file, written on the rising edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wbIn.en) begin
      regs[wbIn.no] <= wbIn.value;
    end
  end

  // Same-cycle writeback passes straight through
  assign rsFile = (wbIn.en && wbIn.no == rs) ? wbIn.value : regs[rs];
  assign rtFile = (wbIn.en && wbIn.no == rt) ? wbIn.value : regs[rt];

  // JAL, LW and the immediate group never read rt
  assign readsRt = op1 inside {ALUR, BEQ, BLT, BLE, BNE, SW};

  // Writer in execute is our own latch, writer in memory comes from execute
  assign rsExDep  = idOut.writeReg && idOut.writeNo == rs;
  assign rtExDep  = readsRt && idOut.writeReg && idOut.writeNo == rt;
  assign rsMemDep = exWriteEn && exWriteNo == rs;
  assign rtMemDep = readsRt && exWriteEn && exWriteNo == rt;

  // Load result is not ready until the memory stage
  assign stall = idOut.readMem && (rsExDep || rtExDep);

  always_comb begin
    idNext.op1      = op1;
    idNext.op2      = op2_e'(feIn.inst[25:18]);
    idNext.imm      = {{(`DATA_BITS-`IMM_BITS){immRaw[`IMM_BITS-1]}}, immRaw};
    idNext.pcPlus4  = feIn.pcPlus4;
    idNext.writeNo  = (op1 == ALUR) ? rd : rt;
    idNext.isBranch = op1 inside {BEQ, BLT, BLE, BNE};
    idNext.isJump   = op1 == JAL;
    idNext.readMem  = op1 == LW;
    idNext.writeMem = op1 == SW;
    idNext.writeReg = op1 inside {ALUR, ADDI, ANDI, ORI, XORI, LW, JAL};
    // Youngest producer first
    idNext.rsVal = rsExDep ? exFwd : rsMemDep ? memFwd : rsFile;
    idNext.rtVal = rtExDep ? exFwd : rtMemDep ? memFwd : rtFile;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      idOut <= '0;
    end else if (stall || redirect) begin
      idOut <= '0;
    end else begin
      idOut <= idNext;
    end
  end

endmodule

//--- hw/executeStage.sv
`timescale 1ns/100ps
`include "cpuConfig.svh"

module executeStage import cpuPkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  idLatch_t idIn,
  output word_t    aluResult,
  output logic     redirect,
  output word_t    redirectPc,
  output regNo_t   exWriteNo,
  output logic     exWriteEn,
  output exLatch_t exOut
);

  word_t a;
  word_t b;
  word_t offset;
  logic  branchCond;

  assign a = idIn.rsVal;
  assign b = idIn.rtVal;

  always_comb begin
    case (idIn.op1)
      ALUR: begin
        case (idIn.op2)
          EQ:      aluResult = word_t'(a == b);
          LT:      aluResult = word_t'($signed(a) < $signed(b));
          LE:      aluResult = word_t'($signed(a) <= $signed(b));
          NE:      aluResult = word_t'(a != b);
          ADD:     aluResult = a + b;
          AND:     aluResult = a & b;
          OR:      aluResult = a | b;
          XOR:     aluResult = a ^ b;
          SUB:     aluResult = a - b;
          NAND:    aluResult = ~(a & b);
          NOR:     aluResult = ~(a | b);
          NXOR:    aluResult = a ~^ b;
          RSHF:    aluResult = a >> b;
          LSHF:    aluResult = a << b;
          default: aluResult = '0;
        endcase
      end
      JAL:          aluResult = idIn.pcPlus4;
      LW, SW, ADDI: aluResult = a + idIn.imm;
      ANDI:         aluResult = a & idIn.imm;
      ORI:          aluResult = a | idIn.imm;
      XORI:         aluResult = a ^ idIn.imm;
      default:      aluResult = '0;
    endcase
  end

  // Signed branch compares
  always_comb begin
    case (idIn.op1)
      BEQ:     branchCond = a == b;
      BLT:     branchCond = $signed(a) < $signed(b);
      BLE:     branchCond = $signed(a) <= $signed(b);
      BNE:     branchCond = a != b;
      default: branchCond = 1'b0;
    endcase
  end

  // Word offset, so the immediate counts instructions
  assign offset     = idIn.imm << 2;
  assign redirect   = (idIn.isBranch && branchCond) || idIn.isJump;
  assign redirectPc = idIn.isJump ? a + offset : idIn.pcPlus4 + offset;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      exOut <= '0;
    end else begin
      exOut.result    <= aluResult;
      exOut.storeData <= b;
      exOut.writeNo   <= idIn.writeNo;
      exOut.readMem   <= idIn.readMem;
      exOut.writeMem  <= idIn.writeMem;
      exOut.writeReg  <= idIn.writeReg;
    end
  end

  // Writer now in memory, seen by decode
  assign exWriteNo = exOut.writeNo;
  assign exWriteEn = exOut.writeReg;

endmodule

//--- hw/memoryStage.sv
`timescale 1ns/100ps
`include "cpuConfig.svh"

module memoryStage import cpuPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  exLatch_t  exIn,
  input  word_t     ioRdData,
  output word_t     memResult,
  output ioReq_t    ioReq,
  output regWrite_t wbOut
);

  localparam int dmemWords = 1 << `DMEM_WORD_BITS;

  word_t dmem [dmemWords];
  logic  isIo;
  word_t dmemRdData;
  word_t loadData;

  // Address decode, top of the address space is I/O
  assign isIo       = exIn.result >= `IO_BASE;
  assign dmemRdData = dmem[exIn.result[`DMEM_WORD_BITS+1:2]];

  always_ff @(posedge clk) begin
    if (exIn.writeMem && !isIo) begin
      dmem[exIn.result[`DMEM_WORD_BITS+1:2]] <= exIn.storeData;
    end
  end

  assign ioReq.addr   = exIn.result;
  assign ioReq.wrData = exIn.storeData;
  assign ioReq.write  = exIn.writeMem && isIo;

  assign loadData  = isIo ? ioRdData : dmemRdData;
  assign memResult = exIn.readMem ? loadData : exIn.result;

  // Writeback latch feeds the register file write port
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wbOut <= '0;
    end else begin
      wbOut.en    <= exIn.writeReg;
      wbOut.no    <= exIn.writeNo;
      wbOut.value <= memResult;
    end
  end

endmodule

//--- hw/outputPorts.sv
`timescale 1ns/100ps
`include "cpuConfig.svh"

module outputPorts import cpuPkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  ioReq_t                     ioReq,
  output word_t                      ioRdData,
  output logic [`LEDR_BITS-1:0]      ledr,
  output logic [7*`HEX_DIGITS-1:0]   hex
);

  logic [4*`HEX_DIGITS-1:0] hexReg;

  // Active-low segments, bit 6 is segment g
  function automatic logic [6:0] sevenSeg(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ledr <= '0;
      hexReg <= `HEX_RESET;
    end else if (ioReq.write) begin
      if (ioReq.addr == `ADDR_LEDR) begin
        ledr <= ioReq.wrData[`LEDR_BITS-1:0];
      end
      if (ioReq.addr == `ADDR_HEX) begin
        hexReg <= ioReq.wrData[4*`HEX_DIGITS-1:0];
      end
    end
  end

  // Readback, zero for unmapped addresses
  assign ioRdData = (ioReq.addr == `ADDR_LEDR) ? word_t'(ledr) :
                    (ioReq.addr == `ADDR_HEX)  ? word_t'(hexReg) : '0;

  // Digit 0 is the lowest nibble
  for (genvar i = 0; i < `HEX_DIGITS; i++) begin : g_digit
    assign hex[7*i +: 7] = sevenSeg(hexReg[4*i +: 4]);
  end

endmodule

//--- hw/cpuTop.sv
`timescale 1ns/100ps
`include "cpuConfig.svh"

module cpuTop import cpuPkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     loadEn,
  input  word_t                    loadAddr,
  input  word_t                    loadData,
  output logic [`LEDR_BITS-1:0]    ledr,
  output logic [7*`HEX_DIGITS-1:0] hex
);

  feLatch_t  feLatch;
  idLatch_t  idLatch;
  exLatch_t  exLatch;
  regWrite_t wbWrite;
  word_t     aluResult;
  word_t     memResult;
  word_t     redirectPc;
  logic      redirect;
  logic      stall;
  regNo_t    exWriteNo;
  logic      exWriteEn;
  ioReq_t    ioReq;
  word_t     ioRdData;

  fetchStage i_fetch (
    .clk, .reset, .stall, .redirect, .redirectPc,
    .loadEn, .loadAddr, .loadData,
    .feOut (feLatch)
  );

  decodeStage i_decode (
    .clk, .reset,
    .feIn   (feLatch),
    .redirect,
    .exFwd  (aluResult),
    .memFwd (memResult),
    .exWriteNo, .exWriteEn,
    .wbIn   (wbWrite),
    .stall,
    .idOut  (idLatch)
  );

  executeStage i_execute (
    .clk, .reset,
    .idIn  (idLatch),
    .aluResult, .redirect, .redirectPc, .exWriteNo, .exWriteEn,
    .exOut (exLatch)
  );

  memoryStage i_memory (
    .clk, .reset,
    .exIn  (exLatch),
    .ioRdData, .memResult, .ioReq,
    .wbOut (wbWrite)
  );

  outputPorts i_outputs (
    .clk, .reset, .ioReq, .ioRdData, .ledr, .hex
  );

endmodule

//--- test/cpuChecker.sv
`timescale 1ns/100ps
`include "cpuConfig.svh"

module cpuChecker import cpuPkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`LEDR_BITS-1:0]    ledr,
  input  logic [7*`HEX_DIGITS-1:0] hex,
  output int                       errorCount,
  output int                       pendingCount
);

  localparam int stepLimit = 2000;

  // Active-low patterns, digit F first down to digit 0
  localparam logic [16*7-1:0] segTable = {
    7'h0E, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
    7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
  };

  typedef struct packed {
    logic                     isHex;
    logic [4*`HEX_DIGITS-1:0] value;
  } change_t;

  word_t   imem [word_t];
  word_t   dmem [word_t];
  change_t expected [$];
  change_t front;
  logic [`LEDR_BITS-1:0]    lastLedr;
  logic [7*`HEX_DIGITS-1:0] lastHex;

  initial begin
    errorCount = 0;
    pendingCount = 0;
  end

  function automatic logic [7*`HEX_DIGITS-1:0] segments(
    input logic [4*`HEX_DIGITS-1:0] value
  );
    logic [7*`HEX_DIGITS-1:0] result;
    for (int i = 0; i < `HEX_DIGITS; i++) begin
      result[7*i +: 7] = segTable[7*value[4*i +: 4] +: 7];
    end
    return result;
  endfunction

  function automatic word_t aluFunction(input logic [7:0] f, input word_t a, input word_t b);
    case (op2_e'(f))
      EQ:      return word_t'(a == b);
      LT:      return word_t'($signed(a) < $signed(b));
      LE:      return word_t'($signed(a) <= $signed(b));
      NE:      return word_t'(a != b);
      ADD:     return a + b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SUB:     return a - b;
      NAND:    return ~(a & b);
      NOR:     return ~(a | b);
      NXOR:    return ~(a ^ b);
      RSHF:    return a >> b;
      LSHF:    return a << b;
      default: return '0;
    endcase
  endfunction

  function automatic logic branchTaken(input op1_e op, input word_t a, input word_t b);
    case (op)
      BEQ:     return a == b;
      BLT:     return $signed(a) < $signed(b);
      BLE:     return $signed(a) <= $signed(b);
      default: return a != b;
    endcase
  endfunction

  function automatic change_t makeChange(input logic isHex, input logic [23:0] value);
    change_t c;
    c.isHex = isHex;
    c.value = value;
    return c;
  endfunction

  task automatic clearModel();
    imem.delete();
    dmem.delete();
    expected.delete();
    pendingCount = 0;
  endtask

  task automatic loadWord(input word_t addr, input word_t data);
    imem[addr] = data;
  endtask

  task automatic checkResetState();
    if (ledr !== '0) begin
      $display("CHECK FAILED ledr after reset: expected %h, got %h", `LEDR_BITS'(0), ledr);
      errorCount++;
    end
    if (hex !== segments(`HEX_RESET)) begin
      $display("CHECK FAILED hex after reset: expected %h, got %h",
               segments(`HEX_RESET), hex);
      errorCount++;
    end
  endtask

  // Instruction-level run from the start address up to the self loop
  task automatic runModel();
    word_t regs [16];
    word_t pc;
    word_t npc;
    word_t inst;
    word_t a;
    word_t b;
    word_t imm;
    word_t addr;
    logic [`LEDR_BITS-1:0]    ledrM;
    logic [4*`HEX_DIGITS-1:0] hexM;
    int steps;
    bit done;
    for (int i = 0; i < 16; i++) begin
      regs[i] = '0;
    end
    expected.delete();
    pc = `START_PC;
    ledrM = '0;
    hexM = `HEX_RESET;
    steps = 0;
    done = 0;
    while (!done) begin
      if (!imem.exists(pc)) begin
        $display("model fetched from %h, outside the loaded program", pc);
        errorCount++;
        done = 1;
      end else if (steps == stepLimit) begin
        $display("model did not reach the end loop in %0d instructions", stepLimit);
        errorCount++;
        done = 1;
      end else begin
        inst = imem[pc];
        a = regs[inst[7:4]];
        b = regs[inst[3:0]];
        imm = {{16{inst[23]}}, inst[23:8]};
        npc = pc + 4;
        case (op1_e'(inst[31:26]))
          ALUR: regs[inst[11:8]] = aluFunction(inst[25:18], a, b);
          ADDI: regs[inst[3:0]] = a + imm;
          ANDI: regs[inst[3:0]] = a & imm;
          ORI:  regs[inst[3:0]] = a | imm;
          XORI: regs[inst[3:0]] = a ^ imm;
          LW: begin
            addr = a + imm;
            if (addr == `ADDR_LEDR) regs[inst[3:0]] = word_t'(ledrM);
            else if (addr == `ADDR_HEX) regs[inst[3:0]] = word_t'(hexM);
            else if (addr < `IO_BASE && dmem.exists(addr)) regs[inst[3:0]] = dmem[addr];
            else regs[inst[3:0]] = '0;
          end
          SW: begin
            addr = a + imm;
            // Only real value changes reach the ports
            if (addr == `ADDR_LEDR && b[`LEDR_BITS-1:0] != ledrM) begin
              ledrM = b[`LEDR_BITS-1:0];
              expected.push_back(makeChange(1'b0, 24'(ledrM)));
            end else if (addr == `ADDR_HEX && b[23:0] != hexM) begin
              hexM = b[23:0];
              expected.push_back(makeChange(1'b1, hexM));
            end else if (addr < `IO_BASE) begin
              dmem[addr] = b;
            end
          end
          BEQ, BLT, BLE, BNE: begin
            if (branchTaken(op1_e'(inst[31:26]), a, b)) npc = pc + 4 + (imm << 2);
          end
          JAL: begin
            regs[inst[3:0]] = pc + 4;
            npc = a + (imm << 2);
          end
          default: begin
            $display("model found unknown opcode %h at %h", inst[31:26], pc);
            errorCount++;
          end
        endcase
        done = npc == pc;
        pc = npc;
        steps++;
      end
    end
    pendingCount = expected.size();
  endtask

  // Ports only move on rising edges, so sample on falling ones
  always @(negedge clk) begin
    if (reset) begin
      lastLedr = ledr;
      lastHex = hex;
    end else begin
      if (ledr !== lastLedr) begin
        if (expected.size() == 0 || expected[0].isHex) begin
          $display("ledr changed to %h where no ledr change was expected", ledr);
          errorCount++;
        end else begin
          front = expected.pop_front();
          if (ledr !== front.value[`LEDR_BITS-1:0]) begin
            $display("CHECK FAILED ledr: expected %h, got %h",
                     front.value[`LEDR_BITS-1:0], ledr);
            errorCount++;
          end
        end
        lastLedr = ledr;
      end
      if (hex !== lastHex) begin
        if (expected.size() == 0 || !expected[0].isHex) begin
          $display("hex changed to %h where no hex change was expected", hex);
          errorCount++;
        end else begin
          front = expected.pop_front();
          if (hex !== segments(front.value)) begin
            $display("CHECK FAILED hex: expected %h, got %h", segments(front.value), hex);
            errorCount++;
          end
        end
        lastHex = hex;
      end
      pendingCount = expected.size();
    end
  end

endmodule

//--- test/cpuTb.sv
`timescale 1ns/100ps
`include "cpuConfig.svh"

module cpuTb import cpuPkg::*; ();

  localparam int numTests = 6;
  localparam int maxWords = 128;
  localparam int drainCycles = 20;

  // Opcode pools for random picks
  localparam logic [14*8-1:0] aluFuncs = {
    EQ, LT, LE, NE, ADD, AND, OR, XOR, SUB, NAND, NOR, NXOR, RSHF, LSHF
  };
  localparam logic [4*6-1:0] immOps = {ADDI, ANDI, ORI, XORI};
  localparam logic [4*6-1:0] branchOps = {BEQ, BLT, BLE, BNE};

  logic                     clk;
  logic                     reset;
  logic                     loadEn;
  word_t                    loadAddr;
  word_t                    loadData;
  logic [`LEDR_BITS-1:0]    ledr;
  logic [7*`HEX_DIGITS-1:0] hex;
  int                       errorCount;
  int                       pendingCount;
  int                       passed;
  int                       failed;
  logic [31:0]              rngState;
  word_t                    prog [$];

  cpuTop i_dut (
    .clk, .reset, .loadEn, .loadAddr, .loadData, .ledr, .hex
  );

  cpuChecker i_checker (
    .clk, .reset, .ledr, .hex, .errorCount, .pendingCount
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] nextRand();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  function automatic word_t encodeR(input op2_e f, input regNo_t rd, input regNo_t rs,
                                    input regNo_t rt);
    return {ALUR, f, 6'b0, rd, rs, rt};
  endfunction

  function automatic word_t encodeI(input op1_e op, input logic [15:0] imm, input regNo_t rs,
                                    input regNo_t rt);
    return {op, 2'b0, imm, rs, rt};
  endfunction

  // Destinations avoid r0 and the two I/O base registers
  function automatic regNo_t randReg();
    return regNo_t'(1 + nextRand() % 13);
  endfunction

  function automatic regNo_t srcReg();
    return regNo_t'(nextRand() % 14);
  endfunction

  function automatic regNo_t outReg();
    return (nextRand() & 1) ? 4'd15 : 4'd14;
  endfunction

  function automatic string testName(input int t);
    case (t)
      0:       return "reset state";
      1:       return "alu chains";
      2:       return "load use";
      3:       return "branches";
      4:       return "jal";
      default: return "io readback";
    endcase
  endfunction

  task automatic emit(input word_t w);
    prog.push_back(w);
  endtask

  // r15 and r14 point at the hex and LED registers
  task automatic emitPrologue();
    prog.delete();
    emit(encodeI(ADDI, 16'hF000, 0, 15));
    emit(encodeI(ADDI, 16'hF020, 0, 14));
  endtask

  task automatic emitEndLoop();
    emit(encodeI(BEQ, 16'hFFFF, 0, 0));
  endtask

  task automatic makeAluChain();
    regNo_t d;
    repeat (30) begin
      d = randReg();
      if (nextRand() & 1) begin
        emit(encodeR(op2_e'(aluFuncs[8*(nextRand() % 14) +: 8]), d, srcReg(), srcReg()));
      end else begin
        emit(encodeI(op1_e'(immOps[6*(nextRand() % 4) +: 6]), 16'(nextRand()), srcReg(), d));
      end
      emit(encodeI(SW, 16'h0, outReg(), d));
    end
  endtask

  task automatic makeLoadUse();
    logic [15:0] addr;
    regNo_t d;
    regNo_t e;
    regNo_t f;
    repeat (8) begin
      addr = 16'((nextRand() % 256) * 4);
      d = randReg();
      e = randReg();
      f = randReg();
      emit(encodeI(ADDI, 16'(nextRand()), 0, d));
      emit(encodeI(SW, addr, 0, d));
      emit(encodeI(LW, addr, 0, e));
      emit(encodeR(ADD, f, e, srcReg()));
      emit(encodeI(SW, 16'h0, 15, f));
    end
  endtask

  task automatic makeBranches();
    int skip;
    emit(encodeI(ADDI, 16'h0111, 0, 5));
    emit(encodeI(ADDI, 16'h0222, 0, 6));
    emit(encodeI(ADDI, 16'h0333, 0, 7));
    repeat (10) begin
      skip = 1 + nextRand() % 3;
      emit(encodeI(ADDI, 16'(int'(nextRand() % 5) - 2), 0, 1));
      emit(encodeI(ADDI, 16'(int'(nextRand() % 5) - 2), 0, 2));
      emit(encodeI(op1_e'(branchOps[6*(nextRand() % 4) +: 6]), 16'(skip), 1, 2));
      for (int i = 0; i < skip; i++) begin
        emit(encodeI(SW, 16'h0, 15, regNo_t'(5 + i)));
      end
      emit(encodeI(ADDI, 16'(nextRand()), 0, 8));
      emit(encodeI(SW, 16'h0, 15, 8));
    end
  endtask

  task automatic makeJumps();
    word_t target;
    int skew;
    emit(encodeI(ADDI, 16'h00AA, 0, 5));
    emit(encodeI(ADDI, 16'h00BB, 0, 6));
    repeat (6) begin
      skew = nextRand() % 3;
      // ADDI, JAL, two skipped stores, then the target
      target = `START_PC + 4 * (prog.size() + 4);
      emit(encodeI(ADDI, 16'(target - 4 * skew), 0, 9));
      emit(encodeI(JAL, 16'(skew), 9, 10));
      emit(encodeI(SW, 16'h0, 15, 5));
      emit(encodeI(SW, 16'h0, 15, 6));
      emit(encodeI(SW, 16'h0, 15, 10));
    end
  endtask

  task automatic makeReadback();
    regNo_t d;
    regNo_t e;
    regNo_t f;
    repeat (8) begin
      d = randReg();
      e = randReg();
      f = randReg();
      emit(encodeI(ADDI, 16'(nextRand()), 0, d));
      emit(encodeI(SW, 16'h0, 14, d));
      emit(encodeI(LW, 16'h0, 14, e));
      emit(encodeI(ADDI, 16'h0001, e, f));
      emit(encodeI(SW, 16'h0, 15, f));
    end
  endtask

  task automatic buildProgram(input int t);
    emitPrologue();
    case (t)
      1:       makeAluChain();
      2:       makeLoadUse();
      3:       makeBranches();
      4:       makeJumps();
      5:       makeReadback();
      default: ;
    endcase
    emitEndLoop();
  endtask

  task automatic runTest(input int t);
    int errorsBefore;
    int cycles;
    bit timedOut;
    errorsBefore = errorCount;
    @(negedge clk);
    reset = 1;
    i_checker.clearModel();
    foreach (prog[i]) begin
      loadEn = 1;
      loadAddr = `START_PC + 4 * i;
      loadData = prog[i];
      i_checker.loadWord(loadAddr, prog[i]);
      @(negedge clk);
    end
    loadEn = 0;
    i_checker.runModel();
    repeat (2) @(negedge clk);
    reset = 0;
    i_checker.checkResetState();
    cycles = 0;
    // Checker counts move on falling edges, read them on rising ones
    while (pendingCount != 0 && cycles < prog.size() * 4 + 10) begin
      @(posedge clk);
      cycles++;
    end
    timedOut = pendingCount != 0;
    if (timedOut) begin
      $display("test %0d %s: %0d expected output changes never appeared", t, testName(t),
               pendingCount);
    end
    // Extra cycles to catch stray output changes
    repeat (drainCycles) @(posedge clk);
    if (timedOut || errorCount != errorsBefore) begin
      failed++;
      $display("test %0d %s: failed", t, testName(t));
    end else begin
      passed++;
      $display("test %0d %s: passed", t, testName(t));
    end
  endtask

  initial begin
    clk = 0;
    reset = 1;
    loadEn = 0;
    loadAddr = '0;
    loadData = '0;
    rngState = 32'd83;
    passed = 0;
    failed = 0;
    for (int t = 0; t < numTests; t++) begin
      buildProgram(t);
      runTest(t);
    end
    $display("tests run %0d, passed %0d, failed %0d, check errors %0d", numTests, passed,
             failed, errorCount);
    if (failed == 0 && errorCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Bound scales with the number of tests and the longest program
  initial begin
    repeat (numTests * maxWords * 8) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", numTests * maxWords * 8);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- compile.f
+incdir+hw
hw/cpuPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/outputPorts.sv
hw/cpuTop.sv
test/cpuChecker.sv
test/cpuTb.sv

//--- Bender.yml
package:
  name: pipelined_cpu

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpuPkg.sv
      - hw/fetchStage.sv
      - hw/decodeStage.sv
      - hw/executeStage.sv
      - hw/memoryStage.sv
      - hw/outputPorts.sv
      - hw/cpuTop.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/cpuChecker.sv
      - test/cpuTb.sv
